//--- Makefile
# Verilator build and run for the instruction front end

VERILATOR ?= verilator
TOP       ?= tb_inst_frontend
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/inst_rom_model.sv
`default_nettype none

module inst_rom_model #(
    parameter int unsigned seed  = 32'h1,
    parameter int          words = 256
) (
    input  wire logic                    clk,
    input  wire logic                    fifo_rst,
    input  wire frontend_pkg::wb_req_t   wb_req,
    output frontend_pkg::wb_rsp_t        wb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_isa_pkg::*;

    localparam int aw = $clog2(words);

    logic [31:0] fill [words];   // random program, kept for reloads
    logic [31:0] mem  [words];
    logic [1:0]  wait_cnt;
    logic        ack_q;
    logic [31:0] dat_q;

    // random word with no control flow, few registers so hazards show up
    function automatic logic [31:0] plain_word(input logic [31:0] raw);
        logic [31:0] w;
        w        = raw;
        w[25:21] = {2'b00, raw[23:21]};
        w[20:16] = {2'b00, raw[18:16]};
        w[15:11] = {2'b00, raw[13:11]};
        if (raw[31]) begin
            w[31:26] = op_special; // half of them R-type
        end
        if (w[31:26] inside {op_j, op_jal, op_beq, op_bne}) begin
            w[31:26] = 6'h09; // addiu
        end
        if (w[31:26] == op_special && w[5:0] inside {funct_jr, funct_jalr}) begin
            w[5:0] = 6'h21; // addu
        end
        return w;
    endfunction

    function automatic void restore_fill();
        for (int i = 0; i < words; i++) begin
            mem[i] = fill[i];
        end
    endfunction

    function automatic void write_word(input logic [31:0] adr, input logic [31:0] w);
        mem[adr[aw+1:2]] = w;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        return mem[adr[aw+1:2]];
    endfunction

    initial begin
        void'($urandom(seed));
        for (int i = 0; i < words; i++) begin
            fill[i] = plain_word($urandom());
            mem[i]  = fill[i];
        end
    end

    // one ack per request after 0 to 3 wait cycles
    always_ff @(posedge clk) begin
        if (fifo_rst || !(wb_req.cyc && wb_req.stb) || ack_q) begin
            ack_q    <= 1'b0;
            wait_cnt <= 2'($urandom_range(3, 0));
        end else if (wait_cnt == 2'd0) begin
            ack_q <= 1'b1;
            dat_q <= mem[wb_req.adr[aw+1:2]];
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    assign wb_rsp.ack = ack_q && wb_req.cyc && wb_req.stb; // no ack once cyc drops
    assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

//--- dv/tb_inst_frontend.sv
`default_nettype none

module tb_inst_frontend;
    timeunit 1ns;
    timeprecision 1ps;
    import frontend_pkg::*;
    import mips_isa_pkg::*;

    localparam logic [31:0] reset_pc = 32'h0000_0100;
    localparam int          n_tests  = 6;
    localparam int          period   = 20;

    typedef enum logic [1:0] {
        duty_always,
        duty_half,
        duty_random
    } duty_t;

    typedef struct packed {
        logic [31:0]      start_pc;
        logic [1:0][31:0] br_pc;     // zero marks an unused entry
        logic [1:0][31:0] br_tgt;
        duty_t            duty;
        logic [31:0]      n_issue;
    } test_row_t;

    localparam test_row_t tests [n_tests] = '{
        '{start_pc: 32'h100, br_pc: '{32'h0, 32'h0}, br_tgt: '{32'h0, 32'h0},
          duty: duty_always, n_issue: 32'd24},
        '{start_pc: 32'h200, br_pc: '{32'h0, 32'h0}, br_tgt: '{32'h0, 32'h0},
          duty: duty_always, n_issue: 32'd40},
        '{start_pc: 32'h100, br_pc: '{32'h248, 32'h10c}, br_tgt: '{32'h120, 32'h240},
          duty: duty_always, n_issue: 32'd30},
        '{start_pc: 32'h100, br_pc: '{32'h310, 32'h108}, br_tgt: '{32'h140, 32'h300},
          duty: duty_half, n_issue: 32'd30},
        '{start_pc: 32'h180, br_pc: '{32'h0, 32'h0}, br_tgt: '{32'h0, 32'h0},
          duty: duty_random, n_issue: 32'd40},
        '{start_pc: 32'h100, br_pc: '{32'h38c, 32'h118}, br_tgt: '{32'h200, 32'h380},
          duty: duty_random, n_issue: 32'd40}
    };

    string test_names [n_tests] = '{"reset_start", "straight_line", "branch_taken",
                                    "slot_held", "random_stall", "random_branch"};

    logic        clk;
    logic        fifo_rst;
    logic        exec_ready;
    redirect_t   redirect;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    issue_slot_t master;
    issue_slot_t slave;
    int          errors;
    int          row_errors;
    int          failed_rows;
    int          limit_cycles;
    string       cur_name;

    inst_frontend_top #(
        .reset_pc (reset_pc),
        .depth    (fifo_depth)
    ) UUT (
        .clk        (clk),
        .fifo_rst   (fifo_rst),
        .exec_ready (exec_ready),
        .redirect   (redirect),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .master     (master),
        .slave      (slave)
    );

    inst_rom_model #(
        .seed (32'h54da2226)
    ) rom (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        limit_cycles = 0;
        for (int i = 0; i < n_tests; i++) begin
            limit_cycles += 40 * int'(tests[i].n_issue);
        end
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: issue stream stalled, run stopped after %0d cycles", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int branch_index(input test_row_t row, input logic [31:0] pc);
        for (int k = 0; k < 2; k++) begin
            if (row.br_pc[k] != 32'd0 && row.br_pc[k] == pc) begin
                return k;
            end
        end
        return -1;
    endfunction

    // R-type writes rd, I-type writes rt, $zero never counts
    function automatic logic depends_on(input logic [31:0] m, input logic [31:0] s);
        logic [4:0] dest;
        dest = (m[31:26] == 6'd0) ? m[15:11] : m[20:16];
        return dest != 5'd0 && (s[25:21] == dest || s[20:16] == dest);
    endfunction

    function automatic logic [31:0] branch_word(input logic [31:0] pc, input logic [31:0] tgt);
        logic [31:0] offset;
        offset = (tgt - pc - 32'd4) >> 2;
        return {op_beq, 5'd0, 5'd0, offset[15:0]};
    endfunction

    task automatic expect_equal(input string field, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            errors++;
            row_errors++;
            $display("mismatch %s %s expected %h actual %h", cur_name, field, exp_val, act_val);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errors++;
            row_errors++;
            $display("%s: %s", cur_name, what);
        end
    endtask

    task automatic run_row(input int r);
        test_row_t   row;
        logic [31:0] exp_pc;
        logic [31:0] fetch_base;
        logic [31:0] tgt;
        logic [31:0] m_inst;
        logic [31:0] s_inst;
        logic        exp_ds;
        logic        pending;
        logic        pair_ok;
        logic        stalled;
        logic        drove_redirect;
        issue_slot_t prev_master;
        issue_slot_t prev_slave;
        int          issued;
        int          duals;
        int          bi;
        int          cycle;
        row         = tests[r];
        cur_name    = test_names[r];
        row_errors  = 0;
        issued      = 0;
        duals       = 0;
        cycle       = 0;
        pending     = 1'b0;
        exp_ds      = 1'b0;
        stalled     = 1'b0;
        tgt         = 32'd0;
        prev_master = '0;
        prev_slave  = '0;
        @(negedge clk);
        fifo_rst   = 1'b1;
        exec_ready = 1'b0;
        redirect   = '0;
        rom.restore_fill();
        for (int k = 0; k < 2; k++) begin
            if (row.br_pc[k] != 32'd0) begin
                rom.write_word(row.br_pc[k], branch_word(row.br_pc[k], row.br_tgt[k]));
            end
        end
        repeat (5) @(negedge clk);
        expect_true(!master.valid && !slave.valid && !wb_req.cyc,
                    "issue lanes or bus active while in reset");
        fifo_rst   = 1'b0;
        exp_pc     = reset_pc;
        fetch_base = reset_pc;
        if (row.start_pc != reset_pc) begin
            redirect   = '{valid: 1'b1, pc: row.start_pc};
            exp_pc     = row.start_pc;
            fetch_base = row.start_pc;
            @(negedge clk);
        end else begin
            @(negedge clk);
            // fetch starts on its own at the reset address
            expect_true(wb_req.cyc && wb_req.stb, "no bus request after reset release");
            expect_equal("first fetch address", reset_pc, wb_req.adr);
        end
        while (issued < int'(row.n_issue)) begin
            redirect = '0;
            case (row.duty)
                duty_always: exec_ready = 1'b1;
                duty_half:   exec_ready = (cycle % 2 == 0);
                default:     exec_ready = 1'($urandom_range(1, 0));
            endcase
            drove_redirect = 1'b0;
            if (pending && master.valid) begin
                // execute resolves the branch once its slot has reached issue
                redirect       = '{valid: 1'b1, pc: tgt};
                drove_redirect = 1'b1;
                pending        = 1'b0;
                fetch_base     = tgt;
            end
            #(period / 4);
            if (stalled && prev_master.valid) begin
                expect_equal("stalled master valid", 32'd1, 32'(master.valid));
                expect_equal("stalled master pc", prev_master.word.pc, master.word.pc);
                expect_equal("stalled master inst", prev_master.word.inst, master.word.inst);
            end
            if (stalled && prev_slave.valid) begin
                expect_equal("stalled slave valid", 32'd1, 32'(slave.valid));
                expect_equal("stalled slave pc", prev_slave.word.pc, slave.word.pc);
            end
            if (master.valid && exec_ready) begin
                m_inst = rom.read_word(exp_pc);
                s_inst = rom.read_word(exp_pc + 32'd4);
                expect_equal("master pc", exp_pc, master.word.pc);
                expect_equal("master inst", m_inst, master.word.inst);
                expect_equal("delay slot flag", 32'(exp_ds), 32'(master.in_delay_slot));
                bi      = branch_index(row, exp_pc);
                pair_ok = bi < 0 && branch_index(row, exp_pc + 32'd4) < 0 && !exp_ds &&
                          !depends_on(m_inst, s_inst);
                if (exp_pc[2] == fetch_base[2]) begin
                    // both words of a fetch pair land in the queue on the same edge
                    expect_equal("slave valid", 32'(pair_ok), 32'(slave.valid));
                end
                if (slave.valid) begin
                    expect_true(pair_ok, "slave issued beside a branch, delay slot or dependency");
                    expect_equal("slave pc", exp_pc + 32'd4, slave.word.pc);
                    expect_equal("slave inst", s_inst, slave.word.inst);
                    expect_equal("slave delay slot flag", 32'd0, 32'(slave.in_delay_slot));
                    duals++;
                end
                issued++;
                if (exp_ds) begin
                    exp_pc = tgt;
                    exp_ds = 1'b0;
                end else if (bi >= 0) begin
                    exp_pc  = exp_pc + 32'd4;
                    exp_ds  = 1'b1;
                    tgt     = row.br_tgt[bi];
                    pending = 1'b1;
                end else begin
                    exp_pc = exp_pc + (slave.valid ? 32'd8 : 32'd4);
                end
            end
            stalled     = !exec_ready && !drove_redirect;
            prev_master = master;
            prev_slave  = slave;
            @(negedge clk);
            cycle++;
        end
        redirect   = '0;
        exec_ready = 1'b0;
        expect_true(duals > 0, "no dual issue seen in the whole test");
        $display("%s: %0d issues, %0d dual, %0d errors", cur_name, issued, duals, row_errors);
        if (row_errors != 0) begin
            failed_rows++;
        end
    endtask

    initial begin
        fifo_rst    = 1'b1;
        exec_ready  = 1'b0;
        redirect    = '0;
        errors      = 0;
        failed_rows = 0;
        for (int r = 0; r < n_tests; r++) begin
            run_row(r);
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests, failed_rows, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'hbfc0_0000
) (
    input  wire logic                      clk,
    input  wire logic                      fifo_rst,
    input  wire logic                      full,
    input  wire frontend_pkg::redirect_t   redirect,
    output frontend_pkg::wb_req_t          wb_req,
    input  wire frontend_pkg::wb_rsp_t     wb_rsp,
    output frontend_pkg::fetch_write_t     fifo_wr
);
    import frontend_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_first,
        st_second
    } fetch_state_t;

    fetch_state_t state;
    logic [31:0]  pc;
    fetch_word_t  first_word;
    logic         wr_valid;
    fetch_word_t  wr_word1;
    fetch_word_t  wr_word2;
    logic         start_pair;

    // queue needs room for both words and no pair still on its way in
    assign start_pair = !full && !wr_valid && !redirect.valid;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            state <= st_idle;
            pc    <= reset_pc;
        end else if (redirect.valid) begin
            state <= st_idle; // abandon transfer, late ack is dropped
            pc    <= redirect.pc;
        end else begin
            case (state)
                st_idle: begin
                    if (start_pair) begin
                        state <= st_first;
                    end
                end
                st_first: begin
                    if (wb_rsp.ack) begin
                        state <= st_second;
                        pc    <= pc + 32'd4;
                    end
                end
                st_second: begin
                    if (wb_rsp.ack) begin
                        state <= st_idle;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_first && wb_rsp.ack) begin
            first_word <= '{pc: pc, inst: wb_rsp.dat}; // wait for its partner
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || redirect.valid) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= (state == st_second) && wb_rsp.ack;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_second && wb_rsp.ack) begin
            wr_word1 <= first_word;
            wr_word2 <= '{pc: pc, inst: wb_rsp.dat};
        end
    end

    always_comb begin
        wb_req.cyc = (state != st_idle);
        wb_req.stb = (state != st_idle);
        wb_req.adr = pc;
    end

    assign fifo_wr = '{en1: wr_valid, en2: wr_valid, word1: wr_word1, word2: wr_word2};

    stb_held_until_ack: assert property (@(posedge clk) disable iff (fifo_rst)
        wb_req.stb && !wb_rsp.ack && !redirect.valid |=> wb_req.stb);

    adr_held_until_ack: assert property (@(posedge clk) disable iff (fifo_rst)
        wb_req.stb && !wb_rsp.ack && !redirect.valid |=> $stable(wb_req.adr));

endmodule

`default_nettype wire

//--- source/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    localparam int fifo_depth = 16;

    // one instruction and where it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_word_t;

    // pair write into the instruction queue
    typedef struct packed {
        logic        en1;
        logic        en2;
        fetch_word_t word1;
        fetch_word_t word2;
    } fetch_write_t;

    typedef struct packed {
        logic        valid;
        fetch_word_t word;
        logic        in_delay_slot;
    } issue_slot_t;

    // restart request from execute, only the target pc
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- source/inst_fifo.sv
`default_nettype none

module inst_fifo #(
    parameter int depth = frontend_pkg::fifo_depth
) (
    input  wire logic                        clk,
    input  wire logic                        fifo_rst,
    input  wire logic                        redirect_valid,
    input  wire frontend_pkg::fetch_write_t  fifo_wr,
    input  wire logic                        read_en1,
    input  wire logic                        read_en2,
    input  wire logic                        master_is_branch,
    output frontend_pkg::issue_slot_t        cand1,
    output frontend_pkg::issue_slot_t        cand2,
    output logic                             full
);
    import frontend_pkg::*;

    localparam int aw = $clog2(depth);
    localparam int cw = aw + 1;

    fetch_word_t   mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [cw-1:0] count;
    logic [cw-1:0] n_push;
    logic [cw-1:0] n_pop;
    logic          empty;
    logic          almost_empty;
    logic          ds_flag;      // next master sits in a delay slot
    logic          hold_valid;
    fetch_word_t   hold_word;
    logic          take_hold;

    assign empty        = (count == '0);
    assign almost_empty = (count == cw'(1));
    assign full         = (count > cw'(depth - 2)); // no room for a pair

    // delay slot already queued when execute redirects
    assign take_hold = redirect_valid && ds_flag && !hold_valid && !empty && !read_en1;

    assign n_push = cw'(fifo_wr.en1) + cw'(fifo_wr.en2);
    assign n_pop  = hold_valid ? '0 : cw'(read_en1) + cw'(read_en2);

    always_ff @(posedge clk) begin
        if (fifo_wr.en1) begin
            mem[wr_ptr] <= fifo_wr.word1;
        end
        if (fifo_wr.en2) begin
            mem[wr_ptr + aw'(1)] <= fifo_wr.word2;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || redirect_valid) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + aw'(n_push);
            rd_ptr <= rd_ptr + aw'(n_pop);
            count  <= count + n_push - n_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            ds_flag <= 1'b0;
        end else if (redirect_valid) begin
            // flag only survives if the slot instruction is kept
            ds_flag <= take_hold || (hold_valid && !read_en1);
        end else if (read_en1) begin
            ds_flag <= master_is_branch && !read_en2;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            hold_valid <= 1'b0;
        end else if (take_hold) begin
            hold_valid <= 1'b1;
        end else if (read_en1) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_hold) begin
            hold_word <= mem[rd_ptr];
        end
    end

    always_comb begin
        cand1.in_delay_slot = ds_flag;
        cand2.in_delay_slot = 1'b0;
        cand2.word          = mem[rd_ptr + aw'(1)];
        if (hold_valid) begin
            // held slot goes first, queue waits behind it
            cand1.valid = 1'b1;
            cand1.word  = hold_word;
            cand2.valid = 1'b0;
        end else begin
            cand1.valid = !empty;
            cand1.word  = mem[rd_ptr];
            cand2.valid = !empty && !almost_empty;
        end
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (fifo_rst)
        fifo_wr.en1 || fifo_wr.en2 |-> !full);

    read2_needs_read1: assert property (@(posedge clk) disable iff (fifo_rst)
        read_en2 |-> read_en1);

endmodule

`default_nettype wire

//--- source/inst_frontend_top.sv
`default_nettype none

module inst_frontend_top #(
    parameter logic [31:0] reset_pc = 32'hbfc0_0000,
    parameter int          depth    = frontend_pkg::fifo_depth
) (
    input  wire logic                     clk,
    input  wire logic                     fifo_rst,
    input  wire logic                     exec_ready,
    input  wire frontend_pkg::redirect_t  redirect,
    output frontend_pkg::wb_req_t         wb_req,
    input  wire frontend_pkg::wb_rsp_t    wb_rsp,
    output frontend_pkg::issue_slot_t     master,
    output frontend_pkg::issue_slot_t     slave
);
    import frontend_pkg::*;

    fetch_write_t fifo_wr;
    issue_slot_t  cand1;
    issue_slot_t  cand2;
    logic         full;
    logic         read_en1;
    logic         read_en2;
    logic         master_is_branch;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .full     (full),
        .redirect (redirect),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .fifo_wr  (fifo_wr)
    );

    inst_fifo #(
        .depth(depth)
    ) u_fifo (
        .clk              (clk),
        .fifo_rst         (fifo_rst),
        .redirect_valid   (redirect.valid),
        .fifo_wr          (fifo_wr),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .cand1            (cand1),
        .cand2            (cand2),
        .full             (full)
    );

    issue_pairing u_pairing (
        .cand1            (cand1),
        .cand2            (cand2),
        .exec_ready       (exec_ready),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .master           (master),
        .slave            (slave)
    );

endmodule

`default_nettype wire

//--- source/issue_pairing.sv
`default_nettype none

module issue_pairing (
    input  wire frontend_pkg::issue_slot_t  cand1,
    input  wire frontend_pkg::issue_slot_t  cand2,
    input  wire logic                       exec_ready,
    output logic                            read_en1,
    output logic                            read_en2,
    output logic                            master_is_branch,
    output frontend_pkg::issue_slot_t       master,
    output frontend_pkg::issue_slot_t       slave
);
    import mips_isa_pkg::*;

    mips_inst_u m_inst;
    mips_inst_u s_inst;
    logic       s_is_branch;
    logic [4:0] m_dest;
    logic       raw_hazard;
    logic       pair_ok;

    assign m_inst = cand1.word.inst;
    assign s_inst = cand2.word.inst;

    assign master_is_branch = is_branch(m_inst);
    assign s_is_branch      = is_branch(s_inst);

    // R-type writes rd, I-type writes rt
    assign m_dest = (m_inst.r.op == op_special) ? m_inst.r.rd : m_inst.i.rt;

    // $zero never creates a dependency
    assign raw_hazard = (m_dest != 5'd0) &&
                        (s_inst.i.rs == m_dest || s_inst.i.rt == m_dest);

    assign pair_ok = cand2.valid
                  && !master_is_branch
                  && !s_is_branch
                  && !cand1.in_delay_slot
                  && !raw_hazard;

    assign read_en1 = cand1.valid && exec_ready;
    assign read_en2 = read_en1 && pair_ok;

    assign master = cand1;

    always_comb begin
        slave               = cand2;
        slave.valid         = cand1.valid && pair_ok; // never issues alone
        slave.in_delay_slot = 1'b0;
    end

endmodule

`default_nettype wire

//--- source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;

    localparam logic [5:0] funct_jr   = 6'b001000;
    localparam logic [5:0] funct_jalr = 6'b001001;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    // same 32 bits, register or immediate layout
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } mips_inst_u;

    function automatic logic is_branch(input mips_inst_u inst);
        logic jump_reg;
        jump_reg = (inst.r.op == op_special) &&
                   (inst.r.funct == funct_jr || inst.r.funct == funct_jalr);
        return jump_reg || (inst.i.op inside {op_beq, op_bne, op_j, op_jal});
    endfunction

endpackage

`default_nettype wire

//--- verilog.f
source/frontend_pkg.sv
source/mips_isa_pkg.sv
source/fetch_unit.sv
source/inst_fifo.sv
source/issue_pairing.sv
source/inst_frontend_top.sv
dv/inst_rom_model.sv
dv/tb_inst_frontend.sv
